// ==== src/coh_defines.svh ====
`ifndef COH_DEFINES_SVH
`define COH_DEFINES_SVH

// cache geometry, one word per line.
`define CACHE_LINES   16
`define INDEX_BITS    4
`define TAG_BITS      26
`define WORD_BITS     32

// address fields.
`define INDEX_LSB     2
`define TAG_LSB       6

// uncached region starts here.
`define NONCACHE_BASE 32'hF000_0000

`endif

// ==== src/coh_pkg.sv ====
package coh_pkg;

    // per-line coherence state.
    typedef enum logic [1:0] {
        INVALID  = 2'b00,
        SHARED   = 2'b01,
        MODIFIED = 2'b10
    } msi_state_t;

    // requests carried on the shared bus.
    typedef enum logic [2:0] {
        BUS_RD     = 3'd0, // read for sharing.
        BUS_RDX    = 3'd1, // read for ownership.
        BUS_UPGR   = 3'd2, // shared to modified, no data.
        BUS_WB     = 3'd3, // victim or flush writeback.
        BUS_UNC_RD = 3'd4,
        BUS_UNC_WR = 3'd5
    } bus_op_t;

endpackage

// ==== src/l1_cache.sv ====
`timescale 1ns/1ns
`include "coh_defines.svh"

module l1_cache
    import coh_pkg::*;
(
    input  logic                  CLK,
    input  logic                  rst,
    // core side
    input  logic [`WORD_BITS-1:0] proc_addr,
    input  logic [`WORD_BITS-1:0] proc_wdata,
    input  logic                  proc_ren,
    input  logic                  proc_wen,
    output logic [`WORD_BITS-1:0] proc_rdata,
    output logic                  proc_busy,
    // flush
    input  logic                  flush,
    output logic                  flush_done,
    // bus request
    output logic                  bus_req,
    output bus_op_t               bus_op,
    output logic [`WORD_BITS-1:0] bus_addr,
    output logic [`WORD_BITS-1:0] bus_wdata,
    input  logic                  bus_done,
    input  logic [`WORD_BITS-1:0] bus_rdata,
    // snoop
    input  logic                  snoop_valid,
    input  bus_op_t               snoop_op,
    input  logic [`WORD_BITS-1:0] snoop_addr,
    output logic                  snoop_dirty,
    output logic [`WORD_BITS-1:0] snoop_data
);
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WB,
        ST_FILL,
        ST_UPGR,
        ST_UNC,
        ST_FLUSH_SCAN,
        ST_FLUSH_WB,
        ST_FLUSH_DONE
    } fsm_t;

    logic [`TAG_BITS-1:0]   tag_arr   [`CACHE_LINES];
    logic [`WORD_BITS-1:0]  data_arr  [`CACHE_LINES];
    msi_state_t             state_arr [`CACHE_LINES];

    fsm_t                   fsm;
    fsm_t                   fsm_next;
    logic [`INDEX_BITS-1:0] flush_idx;
    logic [`INDEX_BITS-1:0] flush_idx_next;

    logic [`INDEX_BITS-1:0] idx;
    logic [`TAG_BITS-1:0]   tag;
    logic [`INDEX_BITS-1:0] snoop_idx;
    logic [`TAG_BITS-1:0]   snoop_tag;
    logic [`INDEX_BITS-1:0] wb_idx;
    logic                   access;
    logic                   uncached;
    logic                   tag_match;
    logic                   hit;
    logic                   snoop_hit;
    logic                   snoop_conflict;
    logic                   done_access;

    logic                   data_we;
    logic [`WORD_BITS-1:0]  data_in;
    logic                   st_we;
    logic [`INDEX_BITS-1:0] st_idx;
    msi_state_t             st_val;

    assign idx       = proc_addr[`INDEX_LSB +: `INDEX_BITS];
    assign tag       = proc_addr[`TAG_LSB +: `TAG_BITS];
    assign access    = proc_ren | proc_wen;
    assign uncached  = (proc_addr >= `NONCACHE_BASE);
    assign tag_match = (state_arr[idx] != INVALID) && (tag_arr[idx] == tag);
    // writes only hit when the line is owned.
    assign hit       = tag_match && (!proc_wen || state_arr[idx] == MODIFIED);

    assign snoop_idx   = snoop_addr[`INDEX_LSB +: `INDEX_BITS];
    assign snoop_tag   = snoop_addr[`TAG_LSB +: `TAG_BITS];
    assign snoop_hit   = snoop_valid && (state_arr[snoop_idx] != INVALID) &&
                         (tag_arr[snoop_idx] == snoop_tag);
    assign snoop_dirty = snoop_hit && (state_arr[snoop_idx] == MODIFIED);
    assign snoop_data  = data_arr[snoop_idx];

    // hold the core off a line the snoop is touching this cycle.
    assign snoop_conflict = snoop_valid && (snoop_idx == idx);

    assign data_in = proc_wen ? proc_wdata : bus_rdata;

    always_comb begin
        fsm_next       = fsm;
        flush_idx_next = flush_idx;
        done_access    = 1'b0;
        data_we        = 1'b0;
        st_we          = 1'b0;
        st_idx         = idx;
        st_val         = INVALID;
        case (fsm)
            ST_IDLE: begin
                if (flush) begin
                    fsm_next       = ST_FLUSH_SCAN;
                    flush_idx_next = '0;
                end else if (access && !snoop_conflict) begin
                    if (uncached) begin
                        fsm_next = ST_UNC;
                    end else if (hit) begin
                        done_access = 1'b1;
                        data_we     = proc_wen;
                    end else if (tag_match) begin
                        fsm_next = ST_UPGR; // write to a shared copy.
                    end else if (state_arr[idx] == MODIFIED) begin
                        fsm_next = ST_WB;
                    end else begin
                        fsm_next = ST_FILL;
                    end
                end
            end
            ST_WB: begin
                if (bus_done) begin
                    st_we    = 1'b1;
                    fsm_next = ST_FILL;
                end
            end
            ST_FILL: begin
                if (bus_done) begin
                    done_access = 1'b1;
                    data_we     = 1'b1;
                    st_we       = 1'b1;
                    st_val      = proc_wen ? MODIFIED : SHARED;
                    fsm_next    = ST_IDLE;
                end
            end
            ST_UPGR: begin
                if (bus_done) begin
                    done_access = 1'b1;
                    data_we     = 1'b1;
                    st_we       = 1'b1;
                    st_val      = MODIFIED;
                    fsm_next    = ST_IDLE;
                end
            end
            ST_UNC: begin
                if (bus_done) begin
                    done_access = 1'b1;
                    fsm_next    = ST_IDLE;
                end
            end
            ST_FLUSH_SCAN: begin
                if (state_arr[flush_idx] == MODIFIED) begin
                    fsm_next = ST_FLUSH_WB;
                end else begin
                    st_we          = 1'b1;
                    st_idx         = flush_idx;
                    flush_idx_next = flush_idx + 1'b1;
                    if (&flush_idx) begin
                        fsm_next = ST_FLUSH_DONE; // last line.
                    end
                end
            end
            ST_FLUSH_WB: begin
                if (bus_done) begin
                    st_we          = 1'b1;
                    st_idx         = flush_idx;
                    flush_idx_next = flush_idx + 1'b1;
                    fsm_next       = (&flush_idx) ? ST_FLUSH_DONE : ST_FLUSH_SCAN;
                end
            end
            ST_FLUSH_DONE: begin
                if (!flush) begin
                    fsm_next = ST_IDLE;
                end
            end
            default: fsm_next = ST_IDLE;
        endcase
    end

    assign proc_busy  = access && !done_access;
    assign proc_rdata = (fsm == ST_IDLE) ? data_arr[idx] : bus_rdata;
    assign flush_done = (fsm == ST_FLUSH_DONE);

    assign wb_idx = (fsm == ST_FLUSH_WB) ? flush_idx : idx;

    always_comb begin
        bus_req   = 1'b1;
        bus_op    = BUS_RD;
        bus_addr  = proc_addr;
        bus_wdata = proc_wdata;
        case (fsm)
            ST_WB, ST_FLUSH_WB: begin
                bus_op    = BUS_WB;
                bus_addr  = {tag_arr[wb_idx], wb_idx, {`INDEX_LSB{1'b0}}};
                bus_wdata = data_arr[wb_idx];
            end
            ST_FILL: bus_op = proc_wen ? BUS_RDX : BUS_RD;
            ST_UPGR: bus_op = BUS_UPGR;
            ST_UNC:  bus_op = proc_wen ? BUS_UNC_WR : BUS_UNC_RD;
            default: bus_req = 1'b0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            fsm       <= ST_IDLE;
            flush_idx <= '0;
        end else begin
            fsm       <= fsm_next;
            flush_idx <= flush_idx_next;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < `CACHE_LINES; i++) begin
                state_arr[i] <= INVALID;
            end
        end else begin
            if (snoop_hit) begin
                if (snoop_op == BUS_RD) begin
                    if (state_arr[snoop_idx] == MODIFIED) begin
                        state_arr[snoop_idx] <= SHARED;
                    end
                end else if (snoop_op == BUS_RDX || snoop_op == BUS_UPGR) begin
                    state_arr[snoop_idx] <= INVALID;
                end
            end
            // own update wins over a snoop on the same line.
            if (st_we) begin
                state_arr[st_idx] <= st_val;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (data_we) begin
            tag_arr[idx]  <= tag;
            data_arr[idx] <= data_in;
        end
    end

endmodule

// ==== src/bus_ctrl.sv ====
`timescale 1ns/1ns
`include "coh_defines.svh"

module bus_ctrl
    import coh_pkg::*;
(
    input  logic                  CLK,
    input  logic                  rst,
    // requests
    input  logic                  req0,
    input  logic                  req1,
    input  bus_op_t               op0,
    input  bus_op_t               op1,
    input  logic [`WORD_BITS-1:0] addr0,
    input  logic [`WORD_BITS-1:0] addr1,
    input  logic [`WORD_BITS-1:0] wdata0,
    input  logic [`WORD_BITS-1:0] wdata1,
    // completion
    output logic                  done0,
    output logic                  done1,
    output logic [`WORD_BITS-1:0] rdata,
    // snoop
    output logic                  snoop_valid0,
    output logic                  snoop_valid1,
    output bus_op_t               snoop_op,
    output logic [`WORD_BITS-1:0] snoop_addr,
    input  logic                  snoop_dirty0,
    input  logic                  snoop_dirty1,
    input  logic [`WORD_BITS-1:0] snoop_data0,
    input  logic [`WORD_BITS-1:0] snoop_data1,
    // memory
    output logic [`WORD_BITS-1:0] memory_addr,
    output logic [`WORD_BITS-1:0] memory_wdata,
    output logic                  memory_ren,
    output logic                  memory_wen,
    input  logic [`WORD_BITS-1:0] memory_rdata,
    input  logic                  memory_busy
);
    typedef enum logic [2:0] {
        B_IDLE,
        B_SNOOP,
        B_SUPPLY,
        B_MEM,
        B_DONE
    } seq_t;

    seq_t                  seq;
    seq_t                  seq_next;
    logic                  gnt;      // index of the granted cache.
    logic                  gnt_next;
    logic                  prio;     // winner when both request.

    bus_op_t               cur_op;
    logic [`WORD_BITS-1:0] cur_addr;
    logic [`WORD_BITS-1:0] cur_wdata;
    logic                  snoopable;
    logic                  mem_read;
    logic                  other_dirty;
    logic [`WORD_BITS-1:0] other_data;

    logic                  load_data;
    logic [`WORD_BITS-1:0] load_value;
    logic [`WORD_BITS-1:0] data_q;

    // round-robin pick.
    assign gnt_next = (req0 && req1) ? prio : req1;

    // requester holds its request until done.
    assign cur_op    = gnt ? op1 : op0;
    assign cur_addr  = gnt ? addr1 : addr0;
    assign cur_wdata = gnt ? wdata1 : wdata0;

    assign snoopable = (cur_op == BUS_RD) || (cur_op == BUS_RDX) || (cur_op == BUS_UPGR);
    assign mem_read  = (cur_op == BUS_RD) || (cur_op == BUS_RDX) || (cur_op == BUS_UNC_RD);

    // the snooped cache is the one not granted.
    assign other_dirty = gnt ? snoop_dirty0 : snoop_dirty1;
    assign other_data  = gnt ? snoop_data0 : snoop_data1;

    always_comb begin
        seq_next   = seq;
        load_data  = 1'b0;
        load_value = memory_rdata;
        case (seq)
            B_IDLE: begin
                if (req0 || req1) begin
                    seq_next = B_SNOOP;
                end
            end
            B_SNOOP: begin
                if (snoopable && other_dirty) begin
                    seq_next   = B_SUPPLY;
                    load_data  = 1'b1;
                    load_value = other_data;
                end else if (cur_op == BUS_UPGR) begin
                    seq_next = B_DONE;
                end else begin
                    seq_next = B_MEM;
                end
            end
            B_SUPPLY: begin
                if (!memory_busy) begin
                    seq_next = B_DONE;
                end
            end
            B_MEM: begin
                if (!memory_busy) begin
                    seq_next  = B_DONE;
                    load_data = mem_read;
                end
            end
            B_DONE:  seq_next = B_IDLE;
            default: seq_next = B_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            seq  <= B_IDLE;
            gnt  <= 1'b0;
            prio <= 1'b0;
        end else begin
            seq <= seq_next;
            if (seq == B_IDLE && (req0 || req1)) begin
                gnt  <= gnt_next;
                prio <= ~gnt_next;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (load_data) begin
            data_q <= load_value;
        end
    end

    assign snoop_op     = cur_op;
    assign snoop_addr   = cur_addr;
    assign snoop_valid0 = (seq == B_SNOOP) && snoopable && gnt;
    assign snoop_valid1 = (seq == B_SNOOP) && snoopable && !gnt;

    // supplied dirty word goes to memory before it is returned.
    assign memory_addr  = cur_addr;
    assign memory_wdata = (seq == B_SUPPLY) ? data_q : cur_wdata;
    assign memory_ren   = (seq == B_MEM) && mem_read;
    assign memory_wen   = (seq == B_SUPPLY) || ((seq == B_MEM) && !mem_read);

    assign done0 = (seq == B_DONE) && !gnt;
    assign done1 = (seq == B_DONE) && gnt;
    assign rdata = data_q;

endmodule

// ==== src/cache_stress_wrapper.sv ====
`timescale 1ns/1ns
`include "coh_defines.svh"

module cache_stress_wrapper
    import coh_pkg::*;
(
    input  logic                  CLK,
    input  logic                  rst,
    // flush
    input  logic                  cache0_flush,
    output logic                  cache0_flush_done,
    input  logic                  cache1_flush,
    output logic                  cache1_flush_done,
    // cache0
    input  logic [`WORD_BITS-1:0] cache0_addr,
    input  logic [`WORD_BITS-1:0] cache0_wdata,
    input  logic                  cache0_ren,
    input  logic                  cache0_wen,
    output logic [`WORD_BITS-1:0] cache0_rdata,
    output logic                  cache0_busy,
    // cache1
    input  logic [`WORD_BITS-1:0] cache1_addr,
    input  logic [`WORD_BITS-1:0] cache1_wdata,
    input  logic                  cache1_ren,
    input  logic                  cache1_wen,
    output logic [`WORD_BITS-1:0] cache1_rdata,
    output logic                  cache1_busy,
    // main memory
    output logic [`WORD_BITS-1:0] memory_addr,
    output logic [`WORD_BITS-1:0] memory_wdata,
    output logic                  memory_ren,
    output logic                  memory_wen,
    input  logic [`WORD_BITS-1:0] memory_rdata,
    input  logic                  memory_busy
);
    logic                  c0_req;
    logic                  c1_req;
    bus_op_t               c0_op;
    bus_op_t               c1_op;
    logic [`WORD_BITS-1:0] c0_addr;
    logic [`WORD_BITS-1:0] c1_addr;
    logic [`WORD_BITS-1:0] c0_wdata;
    logic [`WORD_BITS-1:0] c1_wdata;
    logic                  c0_done;
    logic                  c1_done;
    logic [`WORD_BITS-1:0] bus_rdata;    // shared return path.

    logic                  c0_snoop_valid;
    logic                  c1_snoop_valid;
    bus_op_t               snoop_op;
    logic [`WORD_BITS-1:0] snoop_addr;
    logic                  c0_snoop_dirty;
    logic                  c1_snoop_dirty;
    logic [`WORD_BITS-1:0] c0_snoop_data;
    logic [`WORD_BITS-1:0] c1_snoop_data;

    l1_cache cache0 (
        .CLK(CLK), .rst(rst),
        .proc_addr(cache0_addr), .proc_wdata(cache0_wdata),
        .proc_ren(cache0_ren), .proc_wen(cache0_wen),
        .proc_rdata(cache0_rdata), .proc_busy(cache0_busy),
        .flush(cache0_flush), .flush_done(cache0_flush_done),
        .bus_req(c0_req), .bus_op(c0_op), .bus_addr(c0_addr), .bus_wdata(c0_wdata),
        .bus_done(c0_done), .bus_rdata(bus_rdata),
        .snoop_valid(c0_snoop_valid), .snoop_op(snoop_op), .snoop_addr(snoop_addr),
        .snoop_dirty(c0_snoop_dirty), .snoop_data(c0_snoop_data)
    );

    l1_cache cache1 (
        .CLK(CLK), .rst(rst),
        .proc_addr(cache1_addr), .proc_wdata(cache1_wdata),
        .proc_ren(cache1_ren), .proc_wen(cache1_wen),
        .proc_rdata(cache1_rdata), .proc_busy(cache1_busy),
        .flush(cache1_flush), .flush_done(cache1_flush_done),
        .bus_req(c1_req), .bus_op(c1_op), .bus_addr(c1_addr), .bus_wdata(c1_wdata),
        .bus_done(c1_done), .bus_rdata(bus_rdata),
        .snoop_valid(c1_snoop_valid), .snoop_op(snoop_op), .snoop_addr(snoop_addr),
        .snoop_dirty(c1_snoop_dirty), .snoop_data(c1_snoop_data)
    );

    bus_ctrl bus (
        .CLK(CLK), .rst(rst),
        .req0(c0_req), .req1(c1_req), .op0(c0_op), .op1(c1_op),
        .addr0(c0_addr), .addr1(c1_addr), .wdata0(c0_wdata), .wdata1(c1_wdata),
        .done0(c0_done), .done1(c1_done), .rdata(bus_rdata),
        .snoop_valid0(c0_snoop_valid), .snoop_valid1(c1_snoop_valid),
        .snoop_op(snoop_op), .snoop_addr(snoop_addr),
        .snoop_dirty0(c0_snoop_dirty), .snoop_dirty1(c1_snoop_dirty),
        .snoop_data0(c0_snoop_data), .snoop_data1(c1_snoop_data),
        .memory_addr(memory_addr), .memory_wdata(memory_wdata),
        .memory_ren(memory_ren), .memory_wen(memory_wen),
        .memory_rdata(memory_rdata), .memory_busy(memory_busy)
    );

endmodule

// ==== dv/tb_cache_stress.sv ====
`timescale 1ns/1ns
`include "coh_defines.svh"

module tb_cache_stress;

    localparam int CLK_PERIOD   = 8;
    localparam int SLOTS        = 2048;
    localparam int POOL         = 8;
    localparam int ROUNDS       = 200;
    localparam int ACCESS_WORST = 48; // victim writeback and fill, queued behind the other core.
    localparam int FLUSH_WORST  = `CACHE_LINES * 12 + 8;
    localparam int DIRECTED_OPS = 24;
    localparam int WATCHDOG_CYCLES =
        (DIRECTED_OPS + ROUNDS) * ACCESS_WORST + 3 * FLUSH_WORST + 16;

    logic        CLK;
    logic        rst;
    logic        cache0_flush;
    logic        cache0_flush_done;
    logic        cache1_flush;
    logic        cache1_flush_done;
    logic [31:0] cache0_addr;
    logic [31:0] cache0_wdata;
    logic        cache0_ren;
    logic        cache0_wen;
    logic [31:0] cache0_rdata;
    logic        cache0_busy;
    logic [31:0] cache1_addr;
    logic [31:0] cache1_wdata;
    logic        cache1_ren;
    logic        cache1_wen;
    logic [31:0] cache1_rdata;
    logic        cache1_busy;
    logic [31:0] memory_addr;
    logic [31:0] memory_wdata;
    logic        memory_ren;
    logic        memory_wen;
    logic [31:0] memory_rdata;
    logic        memory_busy;

    logic [31:0] mem     [SLOTS];
    logic [31:0] ref_mem [SLOTS]; // last completed write per word.
    logic [31:0] core0_writes [$];
    int unsigned wait_left;
    int          mem_reads;
    int          mem_writes;
    int          seed = 70;
    logic        samp_ren;
    logic        samp_wen;
    logic        samp_busy;
    logic [31:0] samp_addr;
    logic [31:0] samp_wdata;

    cache_stress_wrapper i_dut (
        .CLK(CLK), .rst(rst),
        .cache0_flush(cache0_flush), .cache0_flush_done(cache0_flush_done),
        .cache1_flush(cache1_flush), .cache1_flush_done(cache1_flush_done),
        .cache0_addr(cache0_addr), .cache0_wdata(cache0_wdata),
        .cache0_ren(cache0_ren), .cache0_wen(cache0_wen),
        .cache0_rdata(cache0_rdata), .cache0_busy(cache0_busy),
        .cache1_addr(cache1_addr), .cache1_wdata(cache1_wdata),
        .cache1_ren(cache1_ren), .cache1_wen(cache1_wen),
        .cache1_rdata(cache1_rdata), .cache1_busy(cache1_busy),
        .memory_addr(memory_addr), .memory_wdata(memory_wdata),
        .memory_ren(memory_ren), .memory_wen(memory_wen),
        .memory_rdata(memory_rdata), .memory_busy(memory_busy)
    );

    // cached and uncached words kept apart.
    function automatic logic [10:0] word_slot(input logic [31:0] addr);
        return {(addr >= `NONCACHE_BASE), addr[11:2]};
    endfunction

    function automatic logic [31:0] slot_addr(input logic [10:0] slot);
        return (slot[10] ? `NONCACHE_BASE : 32'h0) | {20'h0, slot[9:0], 2'b00};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h9E37_79B1) ^ 32'h5EED_0000;
    endfunction

    // two addresses per index over four indexes.
    function automatic logic [31:0] pool_addr(input int i);
        return 32'h0000_0400 + (i % 4) * 4 + (i / 4) * 32'h40;
    endfunction

    assign memory_rdata = mem[word_slot(memory_addr)];
    assign memory_busy  = (memory_ren || memory_wen) && (wait_left != 0);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // memory model, random wait of 0 to 3 cycles per request.
    initial begin
        mem_reads  = 0;
        mem_writes = 0;
        wait_left  = $unsigned($random(seed)) % 4;
        forever begin
            @(posedge CLK);
            samp_ren   = memory_ren;
            samp_wen   = memory_wen;
            samp_busy  = memory_busy;
            samp_addr  = memory_addr;
            samp_wdata = memory_wdata;
            #1;
            if (samp_ren || samp_wen) begin
                if (samp_busy) begin
                    wait_left = wait_left - 1;
                end else begin
                    if (samp_wen) begin
                        mem[word_slot(samp_addr)] = samp_wdata;
                        mem_writes++;
                    end else begin
                        mem_reads++;
                    end
                    wait_left = $unsigned($random(seed)) % 4;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR: t=%0t %s got %h expected %h",
                               $time, name, actual, expected));
        end
    endtask

    // presents one access and holds it until busy is low.
    task automatic core_access(input int core, input logic wr, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output int cycles);
        logic done;
        done   = 1'b0;
        cycles = 0;
        rdata  = '0;
        if (core == 0) begin
            cache0_addr  = addr;
            cache0_wdata = wdata;
            cache0_wen   = wr;
            cache0_ren   = !wr;
        end else begin
            cache1_addr  = addr;
            cache1_wdata = wdata;
            cache1_wen   = wr;
            cache1_ren   = !wr;
        end
        while (!done && cycles < ACCESS_WORST) begin
            @(posedge CLK);
            cycles++;
            done  = (core == 0) ? !cache0_busy : !cache1_busy;
            rdata = (core == 0) ? cache0_rdata : cache1_rdata;
        end
        if (!done) begin
            fail_run($sformatf("core%0d access to %h did not finish in %0d cycles",
                               core, addr, ACCESS_WORST));
        end
        #1;
        if (core == 0) begin
            cache0_ren = 1'b0;
            cache0_wen = 1'b0;
        end else begin
            cache1_ren = 1'b0;
            cache1_wen = 1'b0;
        end
        if (wr) begin
            ref_mem[word_slot(addr)] = wdata;
            if (core == 0) begin
                core0_writes.push_back(addr);
            end
        end
    endtask

    task automatic write_word(input int core, input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        int          cycles;
        core_access(core, 1'b1, addr, data, unused, cycles);
    endtask

    task automatic read_check(input int core, input logic [31:0] addr);
        logic [31:0] data;
        int          cycles;
        core_access(core, 1'b0, addr, '0, data, cycles);
        check_equal($sformatf("cache%0d_rdata[%h]", core, addr), data,
                    ref_mem[word_slot(addr)]);
    endtask

    // holds flush until done, then done must fall with the request.
    task automatic flush_cache(input int core);
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        if (core == 0) begin
            cache0_flush = 1'b1;
        end else begin
            cache1_flush = 1'b1;
        end
        while (!done && waited < FLUSH_WORST) begin
            @(posedge CLK);
            waited++;
            done = (core == 0) ? cache0_flush_done : cache1_flush_done;
        end
        if (!done) begin
            fail_run($sformatf("cache%0d flush never signalled completion", core));
        end
        #1;
        if (core == 0) begin
            cache0_flush = 1'b0;
        end else begin
            cache1_flush = 1'b0;
        end
        @(posedge CLK);
        #1;
        check_equal($sformatf("cache%0d_flush_done", core),
                    (core == 0) ? cache0_flush_done : cache1_flush_done, 1'b0);
    endtask

    task automatic hit_path();
        logic [31:0] addr;
        logic [31:0] data;
        int          cycles;
        addr = 32'h0000_0010;
        write_word(0, addr, 32'h1111_0001);
        for (int n = 0; n < 2; n++) begin
            core_access(0, 1'b0, addr, '0, data, cycles);
            check_equal("cache0_rdata", data, ref_mem[word_slot(addr)]);
            check_equal("cache0 read hit cycles", cycles, 1);
        end
        core_access(0, 1'b1, addr, 32'h1111_0002, data, cycles);
        check_equal("cache0 write hit cycles", cycles, 1);
        read_check(0, addr);
    endtask

    task automatic dirty_sharing();
        logic [31:0] addr;
        addr = 32'h0000_0080;
        write_word(0, addr, 32'h2222_0001);
        read_check(1, addr);
        check_equal("memory[dirty supply]", mem[word_slot(addr)], 32'h2222_0001);
        read_check(0, addr);
    endtask

    task automatic invalidation();
        logic [31:0] addr;
        addr = 32'h0000_00C4;
        read_check(0, addr);
        read_check(1, addr);
        write_word(1, addr, 32'h3333_0001);
        read_check(0, addr); // stale shared copy must be gone.
    endtask

    task automatic evict_and_flush();
        write_word(0, 32'h0000_0300, 32'h4444_0001);
        write_word(0, 32'h0000_0340, 32'h4444_0002); // same index.
        read_check(0, 32'h0000_0300);
        read_check(0, 32'h0000_0340);
        write_word(0, 32'h0000_0308, 32'h4444_0003);
        flush_cache(0);
        foreach (core0_writes[k]) begin
            check_equal($sformatf("memory[%h]", core0_writes[k]),
                        mem[word_slot(core0_writes[k])], ref_mem[word_slot(core0_writes[k])]);
        end
    endtask

    task automatic uncached_region();
        logic [31:0] addr;
        int          reads_before;
        int          writes_before;
        addr          = `NONCACHE_BASE + 32'h40;
        writes_before = mem_writes;
        write_word(0, addr, 32'hCAFE_0005);
        check_equal("memory write count", mem_writes, writes_before + 1);
        check_equal("memory[uncached]", mem[word_slot(addr)], 32'hCAFE_0005);
        for (int n = 0; n < 3; n++) begin
            reads_before = mem_reads;
            read_check(n % 2, addr);
            check_equal("memory read count", mem_reads, reads_before + 1);
        end
    endtask

    task automatic random_op(input int core, input logic wr, input logic [31:0] addr,
                             input logic [31:0] data);
        if (wr) begin
            write_word(core, addr, data);
        end else begin
            read_check(core, addr);
        end
    endtask

    task automatic random_stress();
        int          i0;
        int          i1;
        logic        wr0;
        logic        wr1;
        logic [31:0] d0;
        logic [31:0] d1;
        for (int r = 0; r < ROUNDS; r++) begin
            i0 = $unsigned($random(seed)) % POOL;
            i1 = $unsigned($random(seed)) % POOL;
            if (i1 == i0) begin
                i1 = (i0 + 1) % POOL; // cores stay on different words.
            end
            wr0 = $random(seed);
            wr1 = $random(seed);
            d0  = $random(seed);
            d1  = $random(seed);
            fork
                random_op(0, wr0, pool_addr(i0), d0);
                random_op(1, wr1, pool_addr(i1), d1);
            join
        end
    endtask

    // both caches emptied, so memory alone holds every word.
    task automatic flush_and_compare();
        flush_cache(1);
        flush_cache(0);
        for (int i = 0; i < SLOTS; i++) begin
            check_equal($sformatf("memory[%h]", slot_addr(i)), mem[i], ref_mem[i]);
        end
    endtask

    initial begin
        rst          = 1'b1;
        cache0_flush = 1'b0;
        cache1_flush = 1'b0;
        cache0_addr  = '0;
        cache0_wdata = '0;
        cache0_ren   = 1'b0;
        cache0_wen   = 1'b0;
        cache1_addr  = '0;
        cache1_wdata = '0;
        cache1_ren   = 1'b0;
        cache1_wen   = 1'b0;
        for (int i = 0; i < SLOTS; i++) begin
            mem[i]     = fill_word(slot_addr(i));
            ref_mem[i] = fill_word(slot_addr(i));
        end
        repeat (5) @(posedge CLK);
        #1;
        rst = 1'b0;
        hit_path();
        dirty_sharing();
        invalidation();
        evict_and_flush();
        uncached_region();
        random_stress();
        flush_and_compare();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+src
src/coh_pkg.sv
src/l1_cache.sv
src/bus_ctrl.sv
src/cache_stress_wrapper.sv
dv/tb_cache_stress.sv

// ==== Bender.yml ====
package:
  name: cache_stress

sources:
  - include_dirs:
      - src
    files:
      - src/coh_pkg.sv
      - src/l1_cache.sv
      - src/bus_ctrl.sv
      - src/cache_stress_wrapper.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - dv/tb_cache_stress.sv
